// File: src.f
+incdir+logic
logic/tlx_cmd_pkg.sv
logic/cmd_queue.sv
logic/cmd_arbiter.sv
logic/credit_tracker.sv
logic/cdata_sequencer.sv
logic/tlx_cmd_converter.sv
test/tb_tlx_cmd_converter.sv

// File: Bender.yml
package:
  name: tlx_cmd_converter

sources:
  - include_dirs:
      - logic
    files:
      - logic/tlx_cmd_pkg.sv
      - logic/cmd_queue.sv
      - logic/cmd_arbiter.sv
      - logic/credit_tracker.sv
      - logic/cdata_sequencer.sv
      - logic/tlx_cmd_converter.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/tb_tlx_cmd_converter.sv

// File: test/tb_tlx_cmd_converter.sv
`timescale 1ns/1ps
`default_nettype none

`include "tlx_cmd_settings.svh"

module tb_tlx_cmd_converter;

  import tlx_cmd_pkg::*;

  logic         clock_tlx;
  logic         resetn;
  bdf_t         cfg_bdf;
  logic         wr_cmd_valid;
  tlx_cmd_t     wr_cmd;
  cdata_line_t  wr_cdata;
  logic         wr_cmd_ready;
  logic         rd_cmd_valid;
  tlx_cmd_t     rd_cmd;
  logic         rd_cmd_ready;
  logic         afu_tlx_cmd_valid;
  tlx_cmd_t     afu_tlx_cmd;
  bdf_t         afu_tlx_cmd_bdf;
  logic         afu_tlx_cdata_valid;
  cdata_beat_t  afu_tlx_cdata_bus;
  logic         tlx_afu_cmd_credit;
  logic         tlx_afu_cmd_data_credit;
  cmd_credit_t  tlx_afu_cmd_initial_credit;
  data_credit_t tlx_afu_cmd_data_initial_credit;
  logic [2:0]   fir_fifo_overflow;
  logic [1:0]   fir_tlx_command_credit;

  // observed TLX traffic, one entry per valid cycle
  tlx_cmd_t     got_cmds[$];
  bdf_t         got_bdfs[$];
  int           cmd_cycles[$];
  cdata_beat_t  got_beats[$];
  int           beat_cycles[$];
  int           cycle;
  int           errors;
  int           timeouts;

  tlx_cmd_converter dut_i (.*);

  always #20 clock_tlx = ~clock_tlx;

  // outputs are registered on the rising edge, so the falling edge sees them settled
  always @(negedge clock_tlx)
  begin
    cycle = cycle + 1;
    if (afu_tlx_cmd_valid)
    begin
      got_cmds.push_back(afu_tlx_cmd);
      got_bdfs.push_back(afu_tlx_cmd_bdf);
      cmd_cycles.push_back(cycle);
    end
    if (afu_tlx_cdata_valid)
    begin
      got_beats.push_back(afu_tlx_cdata_bus);
      beat_cycles.push_back(cycle);
    end
  end

  // ----------------------------------------------------------------------
  // stimulus helpers
  // ----------------------------------------------------------------------
  function automatic tlx_cmd_t rand_cmd(input dl_t dl);
    tlx_cmd_t c;
    c.opcode = opcode_t'($urandom);
    c.ea     = ea_t'({$urandom, $urandom, $urandom});
    c.afutag = afutag_t'($urandom);
    c.dl     = dl;
    c.pl     = pl_t'($urandom);
    c.actag  = actag_t'($urandom);
    c.pasid  = pasid_t'($urandom);
    return c;
  endfunction

  function automatic cdata_line_t rand_line();
    cdata_line_t l;
    for (int i = 0; i < 32; i++)
    begin
      l[i*32 +: 32] = $urandom;
    end
    return l;
  endfunction

  // initial credits are taken while reset is low
  task automatic apply_reset(input cmd_credit_t cmd_init, input data_credit_t data_init);
    @(posedge clock_tlx);
    #2;
    tlx_afu_cmd_initial_credit      = cmd_init;
    tlx_afu_cmd_data_initial_credit = data_init;
    resetn = 1'b0;
    repeat (4) @(posedge clock_tlx);
    #2;
    resetn = 1'b1;
    got_cmds.delete();
    got_bdfs.delete();
    cmd_cycles.delete();
    got_beats.delete();
    beat_cycles.delete();
  endtask

  task automatic push_write(input tlx_cmd_t c, input cdata_line_t l);
    @(posedge clock_tlx);
    #2;
    wr_cmd_valid = 1'b1;
    wr_cmd       = c;
    wr_cdata     = l;
    @(posedge clock_tlx);
    #2;
    wr_cmd_valid = 1'b0;
  endtask

  task automatic push_read(input tlx_cmd_t c);
    @(posedge clock_tlx);
    #2;
    rd_cmd_valid = 1'b1;
    rd_cmd       = c;
    @(posedge clock_tlx);
    #2;
    rd_cmd_valid = 1'b0;
  endtask

  task automatic return_credits(input int n_cmd, input int n_data);
    for (int i = 0; i < n_cmd || i < n_data; i++)
    begin
      @(posedge clock_tlx);
      #2;
      tlx_afu_cmd_credit      = (i < n_cmd);
      tlx_afu_cmd_data_credit = (i < n_data);
      @(posedge clock_tlx);
      #2;
      tlx_afu_cmd_credit      = 1'b0;
      tlx_afu_cmd_data_credit = 1'b0;
    end
  endtask

  task automatic wait_count(input int target, input bit for_beats, output bit reached);
    int i;
    i = 0;
    while (i < 200 && ((for_beats ? got_beats.size() : got_cmds.size()) < target))
    begin
      @(posedge clock_tlx);
      i++;
    end
    reached = ((for_beats ? got_beats.size() : got_cmds.size()) >= target);
  endtask

  task automatic expect_count(input int target, input bit for_beats, output bit ok);
    wait_count(target, for_beats, ok);
    if (!ok)
    begin
      $display("timeout after 200 cycles: only %0d of %0d %s seen", 
               for_beats ? got_beats.size() : got_cmds.size(), target,
               for_beats ? "data beats" : "commands");
      timeouts++;
    end
  endtask

  // ----------------------------------------------------------------------
  // compare tasks
  // ----------------------------------------------------------------------
  task automatic check_cmd(input tlx_cmd_t got, input tlx_cmd_t exp, input string what);
    if (got !== exp)
    begin
      $display("ERR %0t: %s command %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_beat(input cdata_beat_t got, input cdata_beat_t exp, input string what);
    if (got !== exp)
    begin
      $display("ERR %0t: %s beat %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_flags(input logic [3:0] got, input logic [3:0] exp, input string what);
    if (got !== exp)
    begin
      $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_bdf(input bdf_t got, input bdf_t exp);
    if (got !== exp)
    begin
      $display("ERR %0t: bdf %h, expected %h", $time, got, exp);
      errors++;
    end
  endtask

  task automatic check_cycle(input int got, input int exp, input string what);
    if (got != exp)
    begin
      $display("ERR %0t: %s in cycle %0d, expected cycle %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  // ----------------------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------------------
  task automatic test_read_passthrough();
    tlx_cmd_t c;
    bit       ok;
    apply_reset(4'd8, 6'd32);
    cfg_bdf = bdf_t'($urandom);
    c = rand_cmd(dl_t'($urandom));
    push_read(c);
    expect_count(1, 1'b0, ok);
    if (ok)
    begin
      check_cmd(got_cmds[0], c, "read");
      check_bdf(got_bdfs[0], cfg_bdf);
    end
  endtask

  task automatic test_write_beats();
    tlx_cmd_t    c64;
    tlx_cmd_t    c128;
    cdata_line_t l64;
    cdata_line_t l128;
    bit          ok;
    bit          cmds_ok;
    apply_reset(4'd8, 6'd32);
    c64  = rand_cmd(2'd1);
    l64  = rand_line();
    c128 = rand_cmd(2'd2);
    l128 = rand_line();
    push_write(c64, l64);
    push_write(c128, l128);
    expect_count(2, 1'b0, cmds_ok);
    expect_count(3, 1'b1, ok);
    if (ok && cmds_ok)
    begin
      check_cmd(got_cmds[0], c64, "64-byte write");
      check_beat(got_beats[0], l64[511:0], "64-byte even");
      check_cycle(beat_cycles[0], cmd_cycles[0], "64-byte even beat");
      check_cmd(got_cmds[1], c128, "128-byte write");
      check_beat(got_beats[1], l128[511:0], "128-byte even");
      check_beat(got_beats[2], l128[1023:512], "128-byte odd");
      check_cycle(beat_cycles[1], cmd_cycles[1], "128-byte even beat");
      check_cycle(beat_cycles[2], cmd_cycles[1] + 1, "128-byte odd beat");
    end
  endtask

  task automatic test_alternation();
    tlx_cmd_t    w0;
    tlx_cmd_t    w1;
    tlx_cmd_t    r0;
    tlx_cmd_t    r1;
    cdata_line_t l0;
    cdata_line_t l1;
    bit          ok;
    apply_reset(4'd0, 6'd32);
    w0 = rand_cmd(2'd2);
    w1 = rand_cmd(2'd1);
    r0 = rand_cmd(dl_t'($urandom));
    r1 = rand_cmd(dl_t'($urandom));
    l0 = rand_line();
    l1 = rand_line();
    push_write(w0, l0);
    push_write(w1, l1);
    push_read(r0);
    push_read(r1);
    return_credits(4, 0);
    expect_count(4, 1'b0, ok);
    if (ok)
    begin
      // read wins the first grant after reset
      check_cmd(got_cmds[0], r0, "first read");
      check_cmd(got_cmds[1], w0, "first write");
      check_cmd(got_cmds[2], r1, "second read");
      check_cmd(got_cmds[3], w1, "second write");
    end
    expect_count(3, 1'b1, ok);
    if (ok)
    begin
      check_beat(got_beats[0], l0[511:0], "first write even");
      check_beat(got_beats[1], l0[1023:512], "first write odd");
      check_beat(got_beats[2], l1[511:0], "second write even");
    end
  endtask

  task automatic test_cmd_credit_gating();
    tlx_cmd_t rd[5];
    bit       ok;
    bit       extra;
    apply_reset(4'd3, 6'd32);
    for (int i = 0; i < 5; i++)
    begin
      rd[i] = rand_cmd(dl_t'($urandom));
      push_read(rd[i]);
    end
    expect_count(3, 1'b0, ok);
    wait_count(4, 1'b0, extra);
    if (extra)
    begin
      $display("ERR %0t: fourth command issued without command credit", $time);
      errors++;
    end
    return_credits(2, 0);
    expect_count(5, 1'b0, ok);
    if (ok)
    begin
      for (int i = 0; i < 5; i++)
      begin
        check_cmd(got_cmds[i], rd[i], "gated read");
      end
    end
  endtask

  task automatic test_data_credit_gating();
    tlx_cmd_t wr[5];
    bit       ok;
    bit       extra;
    apply_reset(4'd8, 6'd6);
    for (int i = 0; i < 5; i++)
    begin
      wr[i] = rand_cmd(2'd2);
      push_write(wr[i], rand_line());
    end
    // 6 data credits cover three lines, then fall below the minimum
    expect_count(3, 1'b0, ok);
    wait_count(4, 1'b0, extra);
    if (extra)
    begin
      $display("ERR %0t: fourth write issued without data credit", $time);
      errors++;
    end
    if (ok)
    begin
      for (int i = 0; i < 3; i++)
      begin
        check_cmd(got_cmds[i], wr[i], "data gated write");
      end
    end
  endtask

  task automatic test_overflow_flags();
    apply_reset(4'd0, 6'd32);
    for (int i = 1; i <= (1 << `TLX_QUEUE_AW); i++)
    begin
      push_read(rand_cmd(dl_t'($urandom)));
      check_flags({3'b000, rd_cmd_ready}, {3'b000, (i < `TLX_QUEUE_HALF)}, "rd_cmd_ready");
    end
    check_flags({1'b0, fir_fifo_overflow}, 4'b0000, "fir_fifo_overflow when full");
    push_read(rand_cmd(dl_t'($urandom)));
    check_flags({1'b0, fir_fifo_overflow}, 4'b0100, "fir_fifo_overflow after extra read");

    // write queue fills on its own, the full read queue does not affect it
    for (int i = 1; i <= `TLX_QUEUE_HALF; i++)
    begin
      push_write(rand_cmd(2'd1), rand_line());
      check_flags({3'b000, wr_cmd_ready}, {3'b000, (i < `TLX_QUEUE_HALF)}, "wr_cmd_ready");
    end

    // both counters start saturated
    apply_reset(4'hf, 6'h3f);
    check_flags({2'b00, fir_tlx_command_credit}, 4'b0000, "credit fault after reset");
    return_credits(1, 0);
    check_flags({2'b00, fir_tlx_command_credit}, 4'b0010, "command credit fault");
    return_credits(0, 1);
    check_flags({2'b00, fir_tlx_command_credit}, 4'b0011, "data credit fault");
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial
  begin
    void'($urandom(39849));
    clock_tlx                       = 1'b0;
    resetn                          = 1'b0;
    cfg_bdf                         = '0;
    wr_cmd_valid                    = 1'b0;
    wr_cmd                          = '0;
    wr_cdata                        = '0;
    rd_cmd_valid                    = 1'b0;
    rd_cmd                          = '0;
    tlx_afu_cmd_credit              = 1'b0;
    tlx_afu_cmd_data_credit         = 1'b0;
    tlx_afu_cmd_initial_credit      = '0;
    tlx_afu_cmd_data_initial_credit = '0;
    cycle                           = 0;
    errors                          = 0;
    timeouts                        = 0;

    test_read_passthrough();
    test_write_beats();
    test_alternation();
    test_cmd_credit_gating();
    test_data_credit_gating();
    test_overflow_flags();

    $display("errors %0d, timeouts %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0)
    begin
      $display("All checks passed");
    end
    else
    begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/tlx_cmd_converter.sv
`timescale 1ns/1ps
`default_nettype none

module tlx_cmd_converter (
  input  wire logic                      clock_tlx,
  input  wire logic                      resetn,
  input  wire tlx_cmd_pkg::bdf_t         cfg_bdf,
  // host write channel
  input  wire logic                      wr_cmd_valid,
  input  wire tlx_cmd_pkg::tlx_cmd_t     wr_cmd,
  input  wire tlx_cmd_pkg::cdata_line_t  wr_cdata,
  output logic                           wr_cmd_ready,
  // host read channel
  input  wire logic                      rd_cmd_valid,
  input  wire tlx_cmd_pkg::tlx_cmd_t     rd_cmd,
  output logic                           rd_cmd_ready,
  // TLX command and write data
  output logic                           afu_tlx_cmd_valid,
  output tlx_cmd_pkg::tlx_cmd_t          afu_tlx_cmd,
  output tlx_cmd_pkg::bdf_t              afu_tlx_cmd_bdf,
  output logic                           afu_tlx_cdata_valid,
  output tlx_cmd_pkg::cdata_beat_t       afu_tlx_cdata_bus,
  // TLX credits
  input  wire logic                      tlx_afu_cmd_credit,
  input  wire logic                      tlx_afu_cmd_data_credit,
  input  wire tlx_cmd_pkg::cmd_credit_t  tlx_afu_cmd_initial_credit,
  input  wire tlx_cmd_pkg::data_credit_t tlx_afu_cmd_data_initial_credit,
  // fault bits
  output logic [2:0]                     fir_fifo_overflow,
  output logic [1:0]                     fir_tlx_command_credit
);

  import tlx_cmd_pkg::*;

  tlx_cmd_t    wr_head;
  tlx_cmd_t    rd_head;
  cdata_line_t data_head;
  logic        wr_avail;
  logic        rd_avail;
  logic        wr_pop;
  logic        rd_pop;
  logic        data_pop;
  logic        issue_ok;
  logic        lane_busy;
  logic        grant;
  logic        grant_is_write;
  dl_t         grant_dl;
  logic        wr_cmd_ovf;
  logic        wr_data_ovf;
  logic        rd_cmd_ovf;

  // ----------------------------------------------------------------------
  // host queues
  // ----------------------------------------------------------------------
  cmd_queue #(.WIDTH($bits(tlx_cmd_t))) wr_cmd_q (
    .clock_tlx, .resetn,
    .push(wr_cmd_valid), .push_data(wr_cmd), .pop(wr_pop), .pop_data(wr_head),
    .not_empty(wr_avail), .ready(wr_cmd_ready), .overflow(wr_cmd_ovf)
  );

  // line queue stays in step with wr_cmd_q, its flags are not needed
  cmd_queue #(.WIDTH($bits(cdata_line_t))) wr_data_q (
    .clock_tlx, .resetn,
    .push(wr_cmd_valid), .push_data(wr_cdata), .pop(data_pop), .pop_data(data_head),
    .not_empty(), .ready(), .overflow(wr_data_ovf)
  );

  cmd_queue #(.WIDTH($bits(tlx_cmd_t))) rd_cmd_q (
    .clock_tlx, .resetn,
    .push(rd_cmd_valid), .push_data(rd_cmd), .pop(rd_pop), .pop_data(rd_head),
    .not_empty(rd_avail), .ready(rd_cmd_ready), .overflow(rd_cmd_ovf)
  );

  // ----------------------------------------------------------------------
  // arbitration, credits and data beats
  // ----------------------------------------------------------------------
  cmd_arbiter arbiter_i (
    .clock_tlx, .resetn,
    .wr_head, .wr_avail, .rd_head, .rd_avail, .issue_ok, .lane_busy,
    .wr_pop, .rd_pop, .grant, .grant_is_write, .grant_dl,
    .cmd_valid(afu_tlx_cmd_valid), .cmd(afu_tlx_cmd)
  );

  credit_tracker credit_i (
    .clock_tlx, .resetn,
    .cmd_initial_credit(tlx_afu_cmd_initial_credit),
    .data_initial_credit(tlx_afu_cmd_data_initial_credit),
    .cmd_credit(tlx_afu_cmd_credit), .data_credit(tlx_afu_cmd_data_credit),
    .grant, .grant_is_write, .grant_dl,
    .issue_ok, .credit_overflow(fir_tlx_command_credit)
  );

  cdata_sequencer cdata_i (
    .clock_tlx, .resetn,
    .grant, .grant_is_write, .grant_dl, .line(data_head),
    .data_pop, .lane_busy,
    .cdata_valid(afu_tlx_cdata_valid), .cdata_bus(afu_tlx_cdata_bus)
  );

  assign afu_tlx_cmd_bdf = cfg_bdf;

  // bit 2 read queue, bit 1 write data queue, bit 0 write command queue
  assign fir_fifo_overflow = {rd_cmd_ovf, wr_data_ovf, wr_cmd_ovf};

endmodule

`default_nettype wire

// File: logic/cdata_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module cdata_sequencer (
  input  wire logic                     clock_tlx,
  input  wire logic                     resetn,
  input  wire logic                     grant,
  input  wire logic                     grant_is_write,
  input  wire tlx_cmd_pkg::dl_t         grant_dl,
  input  wire tlx_cmd_pkg::cdata_line_t line,
  output logic                          data_pop,
  output logic                          lane_busy,
  output logic                          cdata_valid,
  output tlx_cmd_pkg::cdata_beat_t      cdata_bus
);

  import tlx_cmd_pkg::*;

  beat_state_e state;
  cdata_beat_t odd_beat;

  // data line leaves its queue together with the write command
  assign data_pop  = grant && grant_is_write;
  assign lane_busy = (state == BEAT_ODD);

  // ----------------------------------------------------------------------
  // beat control
  // ----------------------------------------------------------------------
  always_ff @(posedge clock_tlx or negedge resetn)
  begin
    if (!resetn)
    begin
      state       <= BEAT_IDLE;
      cdata_valid <= 1'b0;
    end
    else
    begin
      cdata_valid <= data_pop || (state == BEAT_ODD);
      if (state == BEAT_ODD)
      begin
        state <= BEAT_IDLE;
      end
      else if (data_pop && (grant_dl == DL_128B))
      begin
        state <= BEAT_ODD;
      end
    end
  end

  // even half goes out with the command, odd half waits a cycle
  always_ff @(posedge clock_tlx)
  begin
    if (data_pop)
    begin
      cdata_bus <= line[511:0];
      odd_beat  <= line[1023:512];
    end
    else if (state == BEAT_ODD)
    begin
      cdata_bus <= odd_beat;
    end
  end

endmodule

`default_nettype wire

// File: logic/credit_tracker.sv
`timescale 1ns/1ps
`default_nettype none

`include "tlx_cmd_settings.svh"

module credit_tracker (
  input  wire logic                      clock_tlx,
  input  wire logic                      resetn,
  input  wire tlx_cmd_pkg::cmd_credit_t  cmd_initial_credit,
  input  wire tlx_cmd_pkg::data_credit_t data_initial_credit,
  input  wire logic                      cmd_credit,
  input  wire logic                      data_credit,
  input  wire logic                      grant,
  input  wire logic                      grant_is_write,
  input  wire tlx_cmd_pkg::dl_t          grant_dl,
  output logic                           issue_ok,
  output logic [1:0]                     credit_overflow
);

  import tlx_cmd_pkg::*;

  cmd_credit_t  cmd_cnt;
  data_credit_t data_cnt;
  data_credit_t data_cost;
  logic         cmd_wrap;
  logic         data_wrap;

  // data credits charged at the grant, one per 64-byte beat
  always_comb
  begin
    data_cost = '0;
    if (grant && grant_is_write)
    begin
      data_cost = (grant_dl == DL_128B) ? data_credit_t'(2) : data_credit_t'(1);
    end
  end

  assign issue_ok = (cmd_cnt != '0) &&
                    (data_cnt >= data_credit_t'(`TLX_MIN_DATA_CREDIT));

  // a return into a saturated counter with nothing charged would wrap
  assign cmd_wrap  = cmd_credit && !grant && (cmd_cnt == '1);
  assign data_wrap = data_credit && (data_cost == '0) && (data_cnt == '1);

  // initial credits come from the TLX while reset is held
  always_ff @(posedge clock_tlx or negedge resetn)
  begin
    if (!resetn)
    begin
      cmd_cnt         <= cmd_initial_credit;
      data_cnt        <= data_initial_credit;
      credit_overflow <= 2'b00;
    end
    else
    begin
      cmd_cnt  <= cmd_cnt + cmd_credit_t'(cmd_credit) - cmd_credit_t'(grant);
      data_cnt <= data_cnt + data_credit_t'(data_credit) - data_cost;
      if (cmd_wrap)
      begin
        credit_overflow[1] <= 1'b1;
      end
      if (data_wrap)
      begin
        credit_overflow[0] <= 1'b1;
      end
    end
  end

  // arbiter never grants past the credits that are on hand
  assert property (@(posedge clock_tlx) disable iff (!resetn)
    grant |-> (cmd_cnt != '0) && (data_cnt >= data_cost));

endmodule

`default_nettype wire

// File: logic/cmd_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_arbiter (
  input  wire logic                  clock_tlx,
  input  wire logic                  resetn,
  input  wire tlx_cmd_pkg::tlx_cmd_t wr_head,
  input  wire logic                  wr_avail,
  input  wire tlx_cmd_pkg::tlx_cmd_t rd_head,
  input  wire logic                  rd_avail,
  input  wire logic                  issue_ok,
  input  wire logic                  lane_busy,
  output logic                       wr_pop,
  output logic                       rd_pop,
  output logic                       grant,
  output logic                       grant_is_write,
  output tlx_cmd_pkg::dl_t           grant_dl,
  output logic                       cmd_valid,
  output tlx_cmd_pkg::tlx_cmd_t      cmd
);

  import tlx_cmd_pkg::*;

  chan_e turn;
  logic  wr_ok;

  // ----------------------------------------------------------------------
  // grant selection
  // ----------------------------------------------------------------------

  // odd data beat still owns the lane, hold writes one cycle
  assign wr_ok = wr_avail && !lane_busy;

  always_comb
  begin
    grant = issue_ok && (wr_ok || rd_avail);
    if (wr_ok && rd_avail)
    begin
      grant_is_write = (turn == CHAN_WRITE);
    end
    else
    begin
      grant_is_write = wr_ok;
    end
  end

  assign wr_pop   = grant && grant_is_write;
  assign rd_pop   = grant && !grant_is_write;
  assign grant_dl = grant_is_write ? wr_head.dl : rd_head.dl;

  // ----------------------------------------------------------------------
  // turn and TLX command register
  // ----------------------------------------------------------------------

  // read goes first after reset, turn flips on every grant
  always_ff @(posedge clock_tlx or negedge resetn)
  begin
    if (!resetn)
    begin
      turn      <= CHAN_READ;
      cmd_valid <= 1'b0;
    end
    else
    begin
      cmd_valid <= grant;
      if (grant)
      begin
        turn <= (turn == CHAN_READ) ? CHAN_WRITE : CHAN_READ;
      end
    end
  end

  always_ff @(posedge clock_tlx)
  begin
    if (grant)
    begin
      cmd <= grant_is_write ? wr_head : rd_head;
    end
  end

  // only one queue head leaves per cycle
  assert property (@(posedge clock_tlx) disable iff (!resetn) !(wr_pop && rd_pop));

endmodule

`default_nettype wire

// File: logic/cmd_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "tlx_cmd_settings.svh"

module cmd_queue #(
  parameter int WIDTH = 129
) (
  input  wire logic             clock_tlx,
  input  wire logic             resetn,
  input  wire logic             push,
  input  wire logic [WIDTH-1:0] push_data,
  input  wire logic             pop,
  output logic      [WIDTH-1:0] pop_data,
  output logic                  not_empty,
  output logic                  ready,
  output logic                  overflow
);

  localparam int DEPTH = 1 << `TLX_QUEUE_AW;

  logic [WIDTH-1:0]         mem [DEPTH];
  logic [`TLX_QUEUE_AW-1:0] wr_ptr;
  logic [`TLX_QUEUE_AW-1:0] rd_ptr;
  logic [`TLX_QUEUE_AW:0]   count;
  logic                     full;
  logic                     push_ok;
  logic                     pop_ok;

  assign full      = (count == (`TLX_QUEUE_AW+1)'(DEPTH));
  assign not_empty = (count != '0);
  assign push_ok   = push && !full;
  assign pop_ok    = pop && not_empty;

  // host stops sending at half occupancy, leaves room for strobes in flight
  assign ready     = (count < (`TLX_QUEUE_AW+1)'(`TLX_QUEUE_HALF));

  assign pop_data  = mem[rd_ptr];

  // storage
  always_ff @(posedge clock_tlx)
  begin
    if (push_ok)
    begin
      mem[wr_ptr] <= push_data;
    end
  end

  // pointers, occupancy and sticky overflow
  always_ff @(posedge clock_tlx or negedge resetn)
  begin
    if (!resetn)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end
    else
    begin
      if (push_ok)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_ok)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + (`TLX_QUEUE_AW+1)'(push_ok) - (`TLX_QUEUE_AW+1)'(pop_ok);
      // strobe into a full queue is dropped
      if (push && full)
      begin
        overflow <= 1'b1;
      end
    end
  end

  // the arbiter only pops a queue that reported an entry
  assert property (@(posedge clock_tlx) disable iff (!resetn) pop |-> not_empty);

endmodule

`default_nettype wire

// File: logic/tlx_cmd_pkg.sv
`default_nettype none

package tlx_cmd_pkg;

  `include "tlx_cmd_settings.svh"

  // ----------------------------------------------------------------------
  // TLX command fields
  // ----------------------------------------------------------------------
  typedef logic [7:0]  opcode_t;
  // effective address or object handle
  typedef logic [67:0] ea_t;
  typedef logic [15:0] afutag_t;
  // 1 is 64 bytes, 2 is 128 bytes
  typedef logic [1:0]  dl_t;
  typedef logic [2:0]  pl_t;
  typedef logic [11:0] actag_t;
  typedef logic [19:0] pasid_t;

  localparam dl_t DL_128B = 2'd2;

  // 129 bits, pasid in the top bits and opcode in the bottom
  typedef struct packed {
    pasid_t  pasid;
    actag_t  actag;
    pl_t     pl;
    dl_t     dl;
    afutag_t afutag;
    ea_t     ea;
    opcode_t opcode;
  } tlx_cmd_t;

  // ----------------------------------------------------------------------
  // data and configuration
  // ----------------------------------------------------------------------
  typedef logic [511:0]  cdata_beat_t;
  // low half is the even beat
  typedef logic [1023:0] cdata_line_t;
  typedef logic [15:0]   bdf_t;

  typedef logic [`TLX_CMD_CREDIT_W-1:0]  cmd_credit_t;
  typedef logic [`TLX_DATA_CREDIT_W-1:0] data_credit_t;

  // arbiter turn
  typedef enum logic {CHAN_READ = 1'b0, CHAN_WRITE = 1'b1} chan_e;

  // write data beat sequencer
  typedef enum logic {BEAT_IDLE = 1'b0, BEAT_ODD = 1'b1} beat_state_e;

endpackage

`default_nettype wire

// File: logic/tlx_cmd_settings.svh
`ifndef TLX_CMD_SETTINGS_SVH
`define TLX_CMD_SETTINGS_SVH

// ----------------------------------------------------------------------
// queue geometry
// ----------------------------------------------------------------------

// address width of each host-side queue, 16 entries
`define TLX_QUEUE_AW 4

// occupancy at which the host ready flag drops
`define TLX_QUEUE_HALF 8

// ----------------------------------------------------------------------
// TLX credits
// ----------------------------------------------------------------------

// command credit counter width
`define TLX_CMD_CREDIT_W 4

// write data credit counter width
`define TLX_DATA_CREDIT_W 6

// data credits needed before any command may go out
`define TLX_MIN_DATA_CREDIT 2

`endif
